// ==== logic/track_pkg.sv ====
package track_pkg;

  // pixel geometry, sized for a 1280x720 frame
  localparam int HCOUNT_W  = 11;
  localparam int VCOUNT_W  = 10;
  localparam int CHAN_W    = 8;   // one colour or luma/chroma channel
  localparam int SUM_W     = 32;  // coordinate sum over a full frame
  localparam int COUNT_W   = 21;  // masked pixels per frame
  localparam int DIV_STEPS = SUM_W;            // one quotient bit per step
  localparam int STEP_W    = $clog2(DIV_STEPS);
  localparam int COEF_W    = 9;   // signed, holds 129 and -94
  localparam int ACC_W     = 18;  // products and sums of the colour matrix

  typedef logic [HCOUNT_W-1:0] hcount_t;
  typedef logic [VCOUNT_W-1:0] vcount_t;
  typedef logic [CHAN_W-1:0]   chan_t;
  typedef logic [SUM_W-1:0]    sum_t;
  typedef logic [COUNT_W-1:0]  count_t;
  typedef logic [STEP_W-1:0]   step_t;
  typedef logic signed [COEF_W-1:0] coef_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  typedef struct packed {
    logic [4:0] red;   // bits 15..11
    logic [5:0] green; // bits 10..5
    logic [4:0] blue;  // bits 4..0
  } rgb565_t;

  // codes 3 and 7 are unused and select nothing
  typedef enum logic [2:0] {
    CH_GREEN = 3'd0,
    CH_RED   = 3'd1,
    CH_BLUE  = 3'd2,
    CH_LUMA  = 3'd4,
    CH_CR    = 3'd5,
    CH_CB    = 3'd6
  } chan_sel_e;

  // BT.601 integer matrix, result scaled by 256
  localparam coef_t Y_R  = 9'sd66;
  localparam coef_t Y_G  = 9'sd129;
  localparam coef_t Y_B  = 9'sd25;
  localparam coef_t CB_R = -9'sd38;
  localparam coef_t CB_G = -9'sd74;
  localparam coef_t CB_B = 9'sd112;
  localparam coef_t CR_R = 9'sd112;
  localparam coef_t CR_G = -9'sd94;
  localparam coef_t CR_B = -9'sd18;

  localparam acc_t ROUND      = 18'sd128; // half lsb before the shift
  localparam int   COEF_SHIFT = 8;
  localparam acc_t Y_OFFSET   = 18'sd16;
  localparam acc_t C_OFFSET   = 18'sd128;
  localparam acc_t CHAN_MAX   = 18'sd255;

endpackage

// ==== logic/pixel_reconstruct.sv ====
`timescale 1ns/10ps

module pixel_reconstruct (
  input  logic               clk_camera,
  input  logic               sys_rst_pixel,
  input  logic               cam_pclk_i,   // async, from the camera
  input  logic               cam_hsync_i,  // async, high during active line
  input  logic               cam_vsync_i,  // async, rises at frame end
  input  logic [7:0]         cam_data_i,
  output logic               pix_valid_o,
  output track_pkg::rgb565_t pix_data_o,
  output track_pkg::hcount_t pix_hcount_o,
  output track_pkg::vcount_t pix_vcount_o,
  output logic               frame_end_o
);
  import track_pkg::*;

  // two-flop synchronizers
  logic       pclk_s1, pclk_s2;
  logic       hsync_s1, hsync_s2;
  logic       vsync_s1, vsync_s2;
  logic [7:0] data_s1, data_s2;

  // previous synchronized sample for edge detection
  logic pclk_prev, hsync_prev, vsync_prev;

  // edge strobes, registered once before use
  logic       take_byte_q;  // pclk rise inside an active line
  logic       hsync_fall_q;
  logic       vsync_rise_q;
  logic [7:0] byte_q;

  logic    phase_q;  // 0 waits for high byte, 1 waits for low byte
  logic [7:0] high_q;
  hcount_t hcount_q;
  vcount_t vcount_q;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      pclk_s1    <= 1'b0;
      pclk_s2    <= 1'b0;
      hsync_s1   <= 1'b0;
      hsync_s2   <= 1'b0;
      vsync_s1   <= 1'b0;
      vsync_s2   <= 1'b0;
      pclk_prev  <= 1'b0;
      hsync_prev <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      pclk_s1    <= cam_pclk_i;
      pclk_s2    <= pclk_s1;
      hsync_s1   <= cam_hsync_i;
      hsync_s2   <= hsync_s1;
      vsync_s1   <= cam_vsync_i;
      vsync_s2   <= vsync_s1;
      pclk_prev  <= pclk_s2;
      hsync_prev <= hsync_s2;
      vsync_prev <= vsync_s2;
    end
  end

  always_ff @(posedge clk_camera) begin
    data_s1 <= cam_data_i;
    data_s2 <= data_s1;
    byte_q  <= data_s2;  // lines up with take_byte_q
  end

  // stage 1: edge seen in this cycle, registered
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      take_byte_q  <= 1'b0;
      hsync_fall_q <= 1'b0;
      vsync_rise_q <= 1'b0;
    end else begin
      take_byte_q  <= pclk_s2 & ~pclk_prev & hsync_s2;
      hsync_fall_q <= ~hsync_s2 & hsync_prev;
      vsync_rise_q <= vsync_s2 & ~vsync_prev;
    end
  end

  // stage 2: byte pairing and coordinate counters
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      phase_q     <= 1'b0;
      hcount_q    <= '0;
      vcount_q    <= '0;
      pix_valid_o <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      pix_valid_o <= 1'b0;
      frame_end_o <= vsync_rise_q;
      if (take_byte_q) begin
        phase_q <= ~phase_q;
        if (phase_q) begin
          pix_valid_o <= 1'b1;        // second byte completes the pixel
          hcount_q    <= hcount_q + 1'b1;
        end
      end
      if (hsync_fall_q) begin  // end of line
        phase_q  <= 1'b0;
        hcount_q <= '0;
        vcount_q <= vcount_q + 1'b1;
      end
      if (vsync_rise_q) vcount_q <= '0;  // wins over a coincident line end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (take_byte_q && !phase_q) high_q <= byte_q;  // hold first byte
    if (take_byte_q && phase_q) begin
      pix_data_o   <= {high_q, byte_q};
      pix_hcount_o <= hcount_q;
      pix_vcount_o <= vcount_q;
    end
  end

endmodule

// ==== logic/chroma_mask.sv ====
`timescale 1ns/10ps

module chroma_mask (
  input  logic                 clk_camera,
  input  logic                 sys_rst_pixel,
  input  logic                 pix_valid_i,
  input  track_pkg::rgb565_t   pix_data_i,
  input  track_pkg::hcount_t   pix_hcount_i,
  input  track_pkg::vcount_t   pix_vcount_i,
  input  logic                 frame_end_i,
  input  track_pkg::chan_sel_e chan_sel_i,  // stable for a frame
  input  track_pkg::chan_t     lower_i,     // inclusive
  input  track_pkg::chan_t     upper_i,     // inclusive
  output logic                 mask_valid_o,
  output logic                 mask_hit_o,  // read only with mask_valid_o
  output track_pkg::hcount_t   mask_hcount_o,
  output track_pkg::vcount_t   mask_vcount_o,
  output logic                 mask_frame_end_o
);
  import track_pkg::*;

  // side channel, one entry per stage 1..4
  logic    valid_q [1:4];
  logic    fend_q  [1:4];
  hcount_t hcount_q [1:4];
  vcount_t vcount_q [1:4];
  chan_t   red_q   [1:4];
  chan_t   green_q [1:4];
  chan_t   blue_q  [1:4];

  acc_t  prod_y_q [3], prod_cr_q [3], prod_cb_q [3];  // stage 2
  acc_t  sum_y_q, sum_cr_q, sum_cb_q;                 // stage 3
  chan_t y_q, cr_q, cb_q;                             // stage 4

  chan_t sel_chan;
  logic  sel_ok;

  // shift, add offset, saturate to one channel
  function automatic chan_t clip_chan(input acc_t sum, input acc_t offset);
    acc_t scaled;
    scaled = (sum >>> COEF_SHIFT) + offset;
    if (scaled < 0) return '0;
    else if (scaled > CHAN_MAX) return '1;
    else return scaled[CHAN_W-1:0];
  endfunction

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      for (int s = 1; s <= 4; s++) begin
        valid_q[s] <= 1'b0;
        fend_q[s]  <= 1'b0;
      end
    end else begin
      valid_q[1] <= pix_valid_i;
      fend_q[1]  <= frame_end_i;
      for (int s = 2; s <= 4; s++) begin
        valid_q[s] <= valid_q[s-1];
        fend_q[s]  <= fend_q[s-1];
      end
    end
  end

  // stage 1: 565 to 888 by zero fill
  always_ff @(posedge clk_camera) begin
    red_q[1]    <= {pix_data_i.red, 3'b000};
    green_q[1]  <= {pix_data_i.green, 2'b00};
    blue_q[1]   <= {pix_data_i.blue, 3'b000};
    hcount_q[1] <= pix_hcount_i;
    vcount_q[1] <= pix_vcount_i;
    for (int s = 2; s <= 4; s++) begin
      red_q[s]    <= red_q[s-1];
      green_q[s]  <= green_q[s-1];
      blue_q[s]   <= blue_q[s-1];
      hcount_q[s] <= hcount_q[s-1];
      vcount_q[s] <= vcount_q[s-1];
    end
  end

  // stage 2: nine signed products
  always_ff @(posedge clk_camera) begin
    prod_y_q[0]  <= $signed({1'b0, red_q[1]}) * Y_R;
    prod_y_q[1]  <= $signed({1'b0, green_q[1]}) * Y_G;
    prod_y_q[2]  <= $signed({1'b0, blue_q[1]}) * Y_B;
    prod_cr_q[0] <= $signed({1'b0, red_q[1]}) * CR_R;
    prod_cr_q[1] <= $signed({1'b0, green_q[1]}) * CR_G;
    prod_cr_q[2] <= $signed({1'b0, blue_q[1]}) * CR_B;
    prod_cb_q[0] <= $signed({1'b0, red_q[1]}) * CB_R;
    prod_cb_q[1] <= $signed({1'b0, green_q[1]}) * CB_G;
    prod_cb_q[2] <= $signed({1'b0, blue_q[1]}) * CB_B;
  end

  // stage 3: sums with rounding, stage 4: scale, offset and clip
  always_ff @(posedge clk_camera) begin
    sum_y_q  <= prod_y_q[0] + prod_y_q[1] + prod_y_q[2] + ROUND;
    sum_cr_q <= prod_cr_q[0] + prod_cr_q[1] + prod_cr_q[2] + ROUND;
    sum_cb_q <= prod_cb_q[0] + prod_cb_q[1] + prod_cb_q[2] + ROUND;
    y_q  <= clip_chan(sum_y_q, Y_OFFSET);
    cr_q <= clip_chan(sum_cr_q, C_OFFSET);
    cb_q <= clip_chan(sum_cb_q, C_OFFSET);
  end

  always_comb begin
    sel_ok = 1'b1;
    case (chan_sel_i)
      CH_GREEN: sel_chan = green_q[4];
      CH_RED:   sel_chan = red_q[4];
      CH_BLUE:  sel_chan = blue_q[4];
      CH_LUMA:  sel_chan = y_q;
      CH_CR:    sel_chan = cr_q;
      CH_CB:    sel_chan = cb_q;
      default: begin
        sel_chan = '0;
        sel_ok   = 1'b0;  // unused codes never hit
      end
    endcase
  end

  // stage 5: threshold
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      mask_valid_o     <= 1'b0;
      mask_frame_end_o <= 1'b0;
    end else begin
      mask_valid_o     <= valid_q[4];
      mask_frame_end_o <= fend_q[4];
    end
  end

  always_ff @(posedge clk_camera) begin
    mask_hit_o    <= sel_ok && (sel_chan >= lower_i) && (sel_chan <= upper_i);
    mask_hcount_o <= hcount_q[4];
    mask_vcount_o <= vcount_q[4];
  end

endmodule

// ==== logic/com_divider.sv ====
`timescale 1ns/10ps

module com_divider (
  input  logic              clk_camera,
  input  logic              sys_rst_pixel,
  input  logic              start_i,     // loads operands, restarts if busy
  input  track_pkg::sum_t   dividend_i,
  input  track_pkg::count_t divisor_i,   // nonzero
  output track_pkg::sum_t   quotient_o,  // valid with done_o
  output logic              done_o
);
  import track_pkg::*;

  logic   busy_q;
  step_t  step_q;
  count_t divisor_q;
  count_t rem_q;      // partial remainder, always below the divisor

  logic [COUNT_W:0] shifted;  // remainder with next dividend bit
  logic [COUNT_W:0] diff;
  logic             fits;

  // quotient register doubles as the dividend shift register
  assign shifted = {rem_q, quotient_o[SUM_W-1]};
  assign diff    = shifted - {1'b0, divisor_q};
  assign fits    = shifted >= {1'b0, divisor_q};

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      busy_q <= 1'b0;
      step_q <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        if (step_q == STEP_W'(DIV_STEPS - 1)) begin  // last quotient bit
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (start_i) begin
      quotient_o <= dividend_i;
      divisor_q  <= divisor_i;
      rem_q      <= '0;
    end else if (busy_q) begin
      quotient_o <= {quotient_o[SUM_W-2:0], fits};
      // restore by keeping the shifted value when the subtract fails
      rem_q      <= fits ? diff[COUNT_W-1:0] : shifted[COUNT_W-1:0];
    end
  end

endmodule

// ==== logic/center_of_mass.sv ====
`timescale 1ns/10ps

module center_of_mass (
  input  logic               clk_camera,
  input  logic               sys_rst_pixel,
  input  logic               mask_valid_i,
  input  logic               mask_hit_i,
  input  track_pkg::hcount_t mask_hcount_i,
  input  track_pkg::vcount_t mask_vcount_i,
  input  logic               mask_frame_end_i,
  output track_pkg::hcount_t com_x_o,     // holds last good frame
  output track_pkg::vcount_t com_y_o,
  output logic               com_valid_o  // one pulse per nonempty frame
);
  import track_pkg::*;

  logic   hit;
  sum_t   sum_x_q, sum_y_q;
  count_t count_q;
  sum_t   sum_x_next, sum_y_next;  // totals including this cycle's hit
  count_t count_next;
  logic   div_start;

  sum_t quo_x, quo_y;
  logic done_x, done_y;

  always_comb begin
    hit        = mask_valid_i & mask_hit_i;
    sum_x_next = sum_x_q;
    sum_y_next = sum_y_q;
    count_next = count_q;
    if (hit) begin
      sum_x_next = sum_x_q + SUM_W'(mask_hcount_i);
      sum_y_next = sum_y_q + SUM_W'(mask_vcount_i);
      count_next = count_q + 1'b1;
    end
  end

  // an empty frame starts nothing, so outputs keep their values
  assign div_start = mask_frame_end_i && (count_next != '0);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      count_q <= '0;
    end else if (mask_frame_end_i) begin
      sum_x_q <= '0;  // totals go to the dividers this cycle
      sum_y_q <= '0;
      count_q <= '0;
    end else begin
      sum_x_q <= sum_x_next;
      sum_y_q <= sum_y_next;
      count_q <= count_next;
    end
  end

  com_divider div_x (
    .clk_camera   (clk_camera),
    .sys_rst_pixel(sys_rst_pixel),
    .start_i      (div_start),
    .dividend_i   (sum_x_next),
    .divisor_i    (count_next),
    .quotient_o   (quo_x),
    .done_o       (done_x)
  );

  com_divider div_y (
    .clk_camera   (clk_camera),
    .sys_rst_pixel(sys_rst_pixel),
    .start_i      (div_start),
    .dividend_i   (sum_y_next),
    .divisor_i    (count_next),
    .quotient_o   (quo_y),
    .done_o       (done_y)
  );

  // mean is below the largest coordinate, so truncation is lossless
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      com_x_o     <= '0;
      com_y_o     <= '0;
      com_valid_o <= 1'b0;
    end else begin
      com_valid_o <= done_x & done_y;  // both finish together
      if (done_x) com_x_o <= quo_x[HCOUNT_W-1:0];
      if (done_y) com_y_o <= quo_y[VCOUNT_W-1:0];
    end
  end

endmodule

// ==== logic/blob_tracker_top.sv ====
`timescale 1ns/10ps

module blob_tracker_top (
  input  logic                 clk_camera,
  input  logic                 sys_rst_pixel,
  input  logic                 cam_pclk_i,
  input  logic                 cam_hsync_i,
  input  logic                 cam_vsync_i,
  input  logic [7:0]           cam_data_i,
  input  track_pkg::chan_sel_e chan_sel_i,
  input  track_pkg::chan_t     lower_i,
  input  track_pkg::chan_t     upper_i,
  output track_pkg::hcount_t   com_x_o,
  output track_pkg::vcount_t   com_y_o,
  output logic                 com_valid_o
);
  import track_pkg::*;

  // capture to mask pipeline
  logic    pix_valid, frame_end;
  rgb565_t pix_data;
  hcount_t pix_hcount;
  vcount_t pix_vcount;

  // mask pipeline to accumulator, 5 cycles later
  logic    mask_valid, mask_hit, mask_frame_end;
  hcount_t mask_hcount;
  vcount_t mask_vcount;

  pixel_reconstruct capture0 (
    .clk_camera   (clk_camera),
    .sys_rst_pixel(sys_rst_pixel),
    .cam_pclk_i   (cam_pclk_i),
    .cam_hsync_i  (cam_hsync_i),
    .cam_vsync_i  (cam_vsync_i),
    .cam_data_i   (cam_data_i),
    .pix_valid_o  (pix_valid),
    .pix_data_o   (pix_data),
    .pix_hcount_o (pix_hcount),
    .pix_vcount_o (pix_vcount),
    .frame_end_o  (frame_end)
  );

  chroma_mask mask0 (
    .clk_camera      (clk_camera),
    .sys_rst_pixel   (sys_rst_pixel),
    .pix_valid_i     (pix_valid),
    .pix_data_i      (pix_data),
    .pix_hcount_i    (pix_hcount),
    .pix_vcount_i    (pix_vcount),
    .frame_end_i     (frame_end),
    .chan_sel_i      (chan_sel_i),
    .lower_i         (lower_i),
    .upper_i         (upper_i),
    .mask_valid_o    (mask_valid),
    .mask_hit_o      (mask_hit),
    .mask_hcount_o   (mask_hcount),
    .mask_vcount_o   (mask_vcount),
    .mask_frame_end_o(mask_frame_end)
  );

  center_of_mass com0 (
    .clk_camera      (clk_camera),
    .sys_rst_pixel   (sys_rst_pixel),
    .mask_valid_i    (mask_valid),
    .mask_hit_i      (mask_hit),
    .mask_hcount_i   (mask_hcount),
    .mask_vcount_i   (mask_vcount),
    .mask_frame_end_i(mask_frame_end),
    .com_x_o         (com_x_o),
    .com_y_o         (com_y_o),
    .com_valid_o     (com_valid_o)
  );

endmodule

// ==== bench/tracker_checks.svh ====
`ifndef TRACKER_CHECKS_SVH
`define TRACKER_CHECKS_SVH

// first error ends the run
task automatic stop_run(input string why);
  $display("%s", why);
  $display("Checks failed");
  $fatal(1, "stopped at the first error");
endtask

// centre column at full hcount width
task automatic check_com_x(input string test, input hcount_t expected,
                           input hcount_t actual);
  if (actual !== expected)
    stop_run($sformatf("FAIL %s com_x expected %0d actual %0d", test, expected, actual));
endtask

// centre row
task automatic check_com_y(input string test, input vcount_t expected,
                           input vcount_t actual);
  if (actual !== expected)
    stop_run($sformatf("FAIL %s com_y expected %0d actual %0d", test, expected, actual));
endtask

// exactly one pulse for a frame with hits and none for an empty one
task automatic verify_pulses(input string test, input logic want, input int seen);
  if (want && seen == 0)
    stop_run($sformatf("test %s: no com_valid_o pulse after the frame end", test));
  else if (!want && seen != 0)
    stop_run($sformatf("test %s: com_valid_o pulsed for a frame with no hits", test));
  else if (seen > 1)
    stop_run($sformatf("test %s: com_valid_o pulsed %0d times for one frame", test, seen));
endtask

`endif

// ==== bench/tracker_tb.sv ====
`timescale 1ns/10ps

module tracker_tb;
  import track_pkg::*;

  localparam string TRACE_FILE = "bench/tracker_trace.txt";
  localparam int RESULT_WINDOW = 60;  // cycles after the vsync rise at the pins

  logic      clk_camera = 1'b0;
  logic      sys_rst_pixel;
  logic      cam_pclk, cam_hsync, cam_vsync;
  logic [7:0] cam_data;
  chan_sel_e chan_sel;
  chan_t     lower, upper;
  hcount_t   com_x;
  vcount_t   com_y;
  logic      com_valid;

  int    budget_cycles = 0;  // watchdog limit from the trace
  logic  window_open = 1'b0; // a result pulse is allowed only here
  string frames[$];          // trace lines without comment lines

  // fields of the frame under test
  string cur_name;
  int    cur_w, cur_h, cur_bg, cur_left, cur_top, cur_rw, cur_rh, cur_rc;
  int    cur_sel, cur_lower, cur_upper, cur_exp_valid, cur_exp_x, cur_exp_y;

  `include "tracker_checks.svh"

  always #5 clk_camera = ~clk_camera;  // 100 MHz

  blob_tracker_top dut0 (
    .clk_camera   (clk_camera),
    .sys_rst_pixel(sys_rst_pixel),
    .cam_pclk_i   (cam_pclk),
    .cam_hsync_i  (cam_hsync),
    .cam_vsync_i  (cam_vsync),
    .cam_data_i   (cam_data),
    .chan_sel_i   (chan_sel),
    .lower_i      (lower),
    .upper_i      (upper),
    .com_x_o      (com_x),
    .com_y_o      (com_y),
    .com_valid_o  (com_valid)
  );

  task automatic parse_line(input string line);
    int n;
    n = $sscanf(line, "%s %d %d %h %d %d %d %d %h %d %d %d %d %d %d",
                cur_name, cur_w, cur_h, cur_bg, cur_left, cur_top, cur_rw, cur_rh,
                cur_rc, cur_sel, cur_lower, cur_upper, cur_exp_valid, cur_exp_x,
                cur_exp_y);
    if (n != 15) stop_run({"malformed trace line: ", line});
  endtask

  // reads every frame and sums the watchdog budget
  task automatic load_trace();
    int    fd;
    int    total;
    string line;
    total = 200;  // reset and the idle check
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) stop_run("cannot open the trace file bench/tracker_trace.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        parse_line(line);
        frames.push_back(line);
        total += cur_w * cur_h * 8 + cur_h * 8 + 200;  // 8 cycles per pixel
      end
    end
    $fclose(fd);
    if (frames.size() == 0) stop_run("the trace file holds no frames");
    budget_cycles = total;
  endtask

  // rectangle over a flat background
  function automatic logic [15:0] pixel_at(input int x, input int y);
    if (x >= cur_left && x < cur_left + cur_rw && y >= cur_top && y < cur_top + cur_rh)
      return cur_rc[15:0];
    return cur_bg[15:0];
  endfunction

  task automatic apply_settings();
    chan_sel <= chan_sel_e'(cur_sel[2:0]);  // invalid codes pass through as is
    lower    <= cur_lower[7:0];
    upper    <= cur_upper[7:0];
  endtask

  // one pclk period with data set up while pclk is low
  task automatic send_byte(input logic [7:0] b);
    cam_data <= b;
    cam_pclk <= 1'b0;
    repeat (2) @(posedge clk_camera);
    cam_pclk <= 1'b1;  // camera byte is taken here
    repeat (2) @(posedge clk_camera);
  endtask

  task automatic send_row(input int y);
    logic [15:0] pix;
    cam_hsync <= 1'b1;
    repeat (2) @(posedge clk_camera);
    for (int x = 0; x < cur_w; x++) begin
      pix = pixel_at(x, y);
      send_byte(pix[15:8]);  // high byte first
      send_byte(pix[7:0]);
    end
    cam_hsync <= 1'b0;  // line end
    cam_pclk  <= 1'b0;
    repeat (6) @(posedge clk_camera);  // blanking
  endtask

  // vsync pulse and a watch over the whole result window
  task automatic await_result(output int pulses, output hcount_t x_seen,
                              output vcount_t y_seen);
    pulses = 0;
    x_seen = '0;
    y_seen = '0;
    window_open = 1'b1;
    cam_vsync <= 1'b1;
    for (int c = 0; c < RESULT_WINDOW; c++) begin
      @(negedge clk_camera);
      if (com_valid) begin
        pulses++;
        x_seen = com_x;  // new values come with the pulse
        y_seen = com_y;
      end
      @(posedge clk_camera);
      if (c == 3) cam_vsync <= 1'b0;
    end
    window_open = 1'b0;
  endtask

  // no pulse may show up while a frame streams or before the first frame end
  always @(negedge clk_camera) begin
    if (!sys_rst_pixel && com_valid === 1'b1 && !window_open)
      stop_run("com_valid_o pulsed outside the window after a frame end");
  end

  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge clk_camera);
    stop_run("timeout: the run did not finish within the expected number of cycles");
  end

  initial begin
    int      pulses;
    hcount_t x_seen;
    vcount_t y_seen;
    sys_rst_pixel <= 1'b1;
    cam_pclk      <= 1'b0;
    cam_hsync     <= 1'b0;
    cam_vsync     <= 1'b0;
    cam_data      <= 8'h00;
    chan_sel      <= CH_GREEN;
    lower         <= 8'h00;
    upper         <= 8'h00;
    load_trace();
    repeat (2) @(posedge clk_camera);
    sys_rst_pixel <= 1'b0;

    // idle outputs before any frame end
    repeat (20) @(posedge clk_camera);
    @(negedge clk_camera);
    check_com_x("after_reset", '0, com_x);
    check_com_y("after_reset", '0, com_y);
    @(posedge clk_camera);

    foreach (frames[i]) begin
      parse_line(frames[i]);
      apply_settings();
      @(posedge clk_camera);  // settings stable before the first byte
      for (int y = 0; y < cur_h; y++) send_row(y);
      await_result(pulses, x_seen, y_seen);
      verify_pulses(cur_name, cur_exp_valid != 0, pulses);
      if (pulses == 1) begin
        check_com_x(cur_name, hcount_t'(cur_exp_x), x_seen);
        check_com_y(cur_name, vcount_t'(cur_exp_y), y_seen);
      end
      // outputs hold the new centre or the previous one
      @(negedge clk_camera);
      check_com_x(cur_name, hcount_t'(cur_exp_x), com_x);
      check_com_y(cur_name, vcount_t'(cur_exp_y), com_y);
      @(posedge clk_camera);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+bench
logic/track_pkg.sv
logic/pixel_reconstruct.sv
logic/chroma_mask.sv
logic/com_divider.sv
logic/center_of_mass.sv
logic/blob_tracker_top.sv
bench/tracker_tb.sv

// ==== Bender.yml ====
package:
  name: blob_tracker

sources:
  - logic/track_pkg.sv
  - logic/pixel_reconstruct.sv
  - logic/chroma_mask.sv
  - logic/com_divider.sv
  - logic/center_of_mass.sv
  - logic/blob_tracker_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tracker_tb.sv

// ==== bench/tracker_trace.txt ====
# name width height bg_rgb565 left top rect_w rect_h rect_rgb565 sel lower upper
# exp_valid exp_x exp_y ; rgb565 words in hex, the rest decimal
red_thresh 16 12 0000 3 2 6 4 f800 1 128 255 1 5 3
luma_red 16 12 0000 5 4 7 5 f800 4 70 90 1 8 6
cb_red 16 12 0000 9 1 5 6 f800 6 80 100 1 11 3
cr_red 16 12 0000 0 7 3 5 f800 5 200 255 1 1 9
blue_plain 16 12 0000 10 0 6 2 001f 2 200 255 1 12 0
green_lower 16 12 0000 4 3 4 4 0400 0 128 255 1 5 4
green_above 16 12 0000 4 3 4 4 0400 0 129 255 0 5 4
green_upper 16 12 0000 2 5 5 3 0400 0 100 128 1 4 6
green_below 16 12 0000 2 5 5 3 0400 0 100 127 0 4 6
empty_frame 16 12 0000 0 0 0 0 f800 1 128 255 0 4 6
move_a 16 12 0000 1 1 2 2 f800 1 128 255 1 1 1
move_b 16 12 0000 12 8 4 4 f800 1 128 255 1 13 9
corner_pixel 20 10 0000 19 9 1 1 f800 1 128 255 1 19 9
full_luma 20 10 0000 0 0 0 0 0000 4 0 255 1 9 4
bad_sel_3 16 12 f800 0 0 0 0 0000 3 0 255 0 9 4
bad_sel_7 16 12 f800 0 0 0 0 0000 7 0 255 0 9 4
